// File: src/memOpPkg.sv
package memOpPkg;

    typedef logic [31:0] wordT;
    typedef logic [3:0]  laneT;

    // low two bits pick the size class and bit 2 the sign or side
    typedef enum logic [2:0] {
        mtByteU = 3'b000,
        mtHalfU = 3'b001,
        mtWord  = 3'b010,
        mtLeft  = 3'b011,
        mtByteS = 3'b100,
        mtHalfS = 3'b101,
        mtRight = 3'b111
    } memTypeE;

    // codes carried down the pipeline from earlier stages
    typedef enum logic [3:0] {
        excNone  = 4'd0,
        excInt   = 4'd1,
        excAdel  = 4'd2,   // fetch or load address error
        excAdes  = 4'd3,   // store address error
        excSys   = 4'd4,
        excBp    = 4'd5,
        excRi    = 4'd6,
        excEret  = 4'd7,
        excOv    = 4'd8,
        excTrap  = 4'd9,
        excCpu   = 4'd10
    } excCodeE;

endpackage

// File: src/memBusPkg.sv
package memBusPkg;

    typedef logic [31:0] addrT;

    // request machine of the data port
    typedef enum logic [1:0] {
        stIdle = 2'd0,
        stAddr = 2'd1,   // request up and waiting for addr ok
        stData = 2'd2    // accepted and waiting for data ok
    } ctrlStateE;

    // kseg0/kseg1 to physical by clearing the top three bits
    localparam addrT physMask = 32'h1FFF_FFFF;

endpackage

// File: src/storeLaneIf.sv
`timescale 1ns/1ns

interface storeLaneIf import memOpPkg::*; ();

    laneT strobe;
    wordT data;
    logic isWrite;
    logic isRead;

    modport producer (
        output strobe, data, isWrite, isRead
    );

    modport consumer (
        input strobe, data, isWrite, isRead
    );

endinterface

// File: src/storeAlign.sv
`timescale 1ns/1ns

module storeAlign import memOpPkg::*; (
    input  memTypeE      memType,
    input  logic [1:0]   addrLow,
    input  wordT         storeData,
    input  logic         memRead,
    input  logic         memWrite,
    storeLaneIf.producer lane
);

    laneT strobe;
    wordT data;

    always_comb begin
        strobe = '0;
        data   = '0;
        case (memType)
            mtByteU, mtByteS: begin
                strobe = 4'b0001 << addrLow;
                data   = {24'b0, storeData[7:0]} << {addrLow, 3'b000};
            end
            mtHalfU, mtHalfS: begin
                case (addrLow)
                    2'b00: begin
                        strobe     = 4'b0011;
                        data[15:0] = storeData[15:0];
                    end
                    2'b10: begin
                        strobe      = 4'b1100;
                        data[31:16] = storeData[15:0];
                    end
                    default: ;   // nothing written at odd offsets
                endcase
            end
            mtWord: begin
                strobe = 4'b1111;
                data   = storeData;
            end
            mtLeft: begin   // swl puts upper register bytes in lanes 0..offset
                case (addrLow)
                    2'b00: begin
                        strobe    = 4'b0001;
                        data[7:0] = storeData[31:24];
                    end
                    2'b01: begin
                        strobe     = 4'b0011;
                        data[15:0] = storeData[31:16];
                    end
                    2'b10: begin
                        strobe     = 4'b0111;
                        data[23:0] = storeData[31:8];
                    end
                    default: begin
                        strobe = 4'b1111;
                        data   = storeData;
                    end
                endcase
            end
            mtRight: begin  // swr puts lower register bytes in lanes offset..3
                case (addrLow)
                    2'b00: begin
                        strobe = 4'b1111;
                        data   = storeData;
                    end
                    2'b01: begin
                        strobe     = 4'b1110;
                        data[31:8] = storeData[23:0];
                    end
                    2'b10: begin
                        strobe      = 4'b1100;
                        data[31:16] = storeData[15:0];
                    end
                    default: begin
                        strobe      = 4'b1000;
                        data[31:24] = storeData[7:0];
                    end
                endcase
            end
            default: ;
        endcase
    end

    assign lane.strobe  = strobe;
    assign lane.data    = data;
    assign lane.isWrite = memWrite;
    assign lane.isRead  = memRead;

endmodule

// File: src/loadAlign.sv
`timescale 1ns/1ns

module loadAlign import memOpPkg::*; (
    input  memTypeE    memType,
    input  logic [1:0] addrLow,
    input  wordT       readWord,
    output wordT       loadData,
    output laneT       rfByteEn
);

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    // lane picked by the byte offset
    always_comb begin
        case (addrLow)
            2'b00:   byteSel = readWord[7:0];
            2'b01:   byteSel = readWord[15:8];
            2'b10:   byteSel = readWord[23:16];
            default: byteSel = readWord[31:24];
        endcase
    end

    assign halfSel = addrLow[1] ? readWord[31:16] : readWord[15:0];

    always_comb begin
        loadData = readWord;
        rfByteEn = 4'b1111;
        case (memType)
            mtByteU: loadData = {24'b0, byteSel};
            mtByteS: loadData = {{24{byteSel[7]}}, byteSel};
            mtHalfU: loadData = {16'b0, halfSel};
            mtHalfS: loadData = {{16{halfSel[15]}}, halfSel};
            mtWord:  loadData = readWord;
            mtLeft: begin   // lwl moves memory bytes 0..offset to the top
                case (addrLow)
                    2'b00: begin
                        loadData = {readWord[7:0], 24'b0};
                        rfByteEn = 4'b1000;
                    end
                    2'b01: begin
                        loadData = {readWord[15:0], 16'b0};
                        rfByteEn = 4'b1100;
                    end
                    2'b10: begin
                        loadData = {readWord[23:0], 8'b0};
                        rfByteEn = 4'b1110;
                    end
                    default: ;  // whole word
                endcase
            end
            mtRight: begin  // lwr moves memory bytes offset..3 to the bottom
                case (addrLow)
                    2'b01: begin
                        loadData = {8'b0, readWord[31:8]};
                        rfByteEn = 4'b0111;
                    end
                    2'b10: begin
                        loadData = {16'b0, readWord[31:16]};
                        rfByteEn = 4'b0011;
                    end
                    2'b11: begin
                        loadData = {24'b0, readWord[31:24]};
                        rfByteEn = 4'b0001;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: src/memAccessCtrl.sv
`timescale 1ns/1ns

module memAccessCtrl import memOpPkg::*, memBusPkg::*; (
    input  logic         clk,
    input  logic         rst,
    storeLaneIf.consumer lane,
    input  wordT         aluOut,
    input  wordT         pcIn,
    input  excCodeE      excIn,
    input  wordT         memRdata,
    input  logic         memAddrOk,
    input  logic         memDataOk,
    output logic         memReq,
    output logic         memWr,
    output addrT         memAddr,
    output laneT         memStrb,
    output wordT         memWdata,
    output logic         stall,
    output wordT         readWord
);

    ctrlStateE state;
    ctrlStateE stateNext;
    excCodeE   prevExc;
    wordT      rdataQ;
    logic      suppress;
    logic      access;
    logic      issue;
    logic      dataDone;

    always_ff @(posedge clk) begin
        if (rst) begin
            prevExc <= excNone;
        end else begin
            prevExc <= excIn;
        end
    end

    // drop faulting accesses including loads
    assign suppress = (excIn != excNone) || (pcIn[1:0] != 2'b00)
                   || (prevExc != excNone && prevExc != excEret);
    assign access   = (lane.isRead || lane.isWrite) && !suppress;
    assign issue    = (state == stIdle) && access;
    assign dataDone = (state == stData) && memDataOk;

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                if (issue) begin
                    stateNext = memAddrOk ? stData : stAddr;
                end
            end
            stAddr: begin
                if (memAddrOk) begin
                    stateNext = stData;
                end
            end
            stData: begin
                if (memDataOk) begin
                    stateNext = stIdle;
                end
            end
            default: stateNext = stIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk) begin
        if (dataDone) begin
            rdataQ <= memRdata;
        end
    end

    assign memReq   = issue || (state == stAddr);
    assign stall    = memReq || ((state == stData) && !memDataOk);
    assign memWr    = lane.isWrite;
    assign memAddr  = aluOut & physMask;
    assign memStrb  = lane.strobe;
    assign memWdata = lane.data;
    assign readWord = dataDone ? memRdata : rdataQ;   // held copy after data ok

endmodule

// File: src/memStage.sv
`timescale 1ns/1ns

module memStage import memOpPkg::*, memBusPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  memTypeE memType,
    input  logic    memRead,
    input  logic    memWrite,
    input  logic    memToReg,
    input  wordT    aluOut,
    input  wordT    storeData,
    input  wordT    pcIn,
    input  excCodeE excIn,
    input  wordT    memRdata,
    input  logic    memAddrOk,
    input  logic    memDataOk,
    output wordT    writeData,
    output laneT    rfByteEn,
    output logic    stall,
    output logic    memReq,
    output logic    memWr,
    output addrT    memAddr,
    output laneT    memStrb,
    output wordT    memWdata
);

    wordT readWord;
    wordT loadData;
    laneT loadByteEn;

    storeLaneIf laneBus ();

    storeAlign i_storeAlign (
        .memType   (memType),
        .addrLow   (aluOut[1:0]),
        .storeData (storeData),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .lane      (laneBus.producer)
    );

    memAccessCtrl i_memAccessCtrl (
        .clk       (clk),
        .rst       (rst),
        .lane      (laneBus.consumer),
        .aluOut    (aluOut),
        .pcIn      (pcIn),
        .excIn     (excIn),
        .memRdata  (memRdata),
        .memAddrOk (memAddrOk),
        .memDataOk (memDataOk),
        .memReq    (memReq),
        .memWr     (memWr),
        .memAddr   (memAddr),
        .memStrb   (memStrb),
        .memWdata  (memWdata),
        .stall     (stall),
        .readWord  (readWord)
    );

    loadAlign i_loadAlign (
        .memType  (memType),
        .addrLow  (aluOut[1:0]),
        .readWord (readWord),
        .loadData (loadData),
        .rfByteEn (loadByteEn)
    );

    // partial register writes only come from loads
    assign writeData = memToReg ? loadData : aluOut;
    assign rfByteEn  = memToReg ? loadByteEn : 4'b1111;

endmodule

// File: testbench/sramResponder.sv
`timescale 1ns/1ns

module sramResponder import memOpPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        memReq,
    input  logic        memWr,
    input  logic [31:0] memAddr,
    input  laneT        memStrb,
    input  wordT        memWdata,
    output logic        memAddrOk,
    output logic        memDataOk,
    output wordT        memRdata,
    output int          acceptCnt,
    output logic        logWr,
    output logic [31:0] logAddr,
    output laneT        logStrb,
    output wordT        logWdata
);

    integer seed = 32'hc417;
    logic   busy;
    int     waitCnt;

    always @(posedge clk) begin
        if (rst) begin
            memAddrOk <= 1'b0;
            memDataOk <= 1'b0;
            memRdata  <= '0;
            busy      <= 1'b0;
            waitCnt   <= 0;
            acceptCnt <= 0;
            logWr     <= 1'b0;
            logAddr   <= '0;
            logStrb   <= '0;
            logWdata  <= '0;
        end else if (!busy) begin
            memDataOk <= 1'b0;
            if (memReq && memAddrOk) begin  // log the accepted request
                memAddrOk <= 1'b0;
                busy      <= 1'b1;
                waitCnt   <= {$random(seed)} % 4;
                acceptCnt <= acceptCnt + 1;
                logWr     <= memWr;
                logAddr   <= memAddr;
                logStrb   <= memStrb;
                logWdata  <= memWdata;
            end else if (memReq) begin
                if (waitCnt == 0) begin
                    memAddrOk <= 1'b1;
                end else begin
                    waitCnt <= waitCnt - 1;
                end
            end
        end else begin
            if (waitCnt == 0) begin
                memDataOk <= 1'b1;
                memRdata  <= (logAddr >> 2) ^ 32'h5A3C_96E1;  // fill from word address
                busy      <= 1'b0;
                waitCnt   <= {$random(seed)} % 4;   // next address wait
            end else begin
                waitCnt <= waitCnt - 1;
            end
        end
    end

endmodule

// File: testbench/memStageTb.sv
`timescale 1ns/1ns

module memStageTb import memOpPkg::*; ();

    localparam int opCount    = 400;
    localparam int resetCycles = 10;
    localparam int cycleLimit = opCount * 12 + resetCycles + 20;

    logic        clk;
    logic        rst;
    memTypeE     memType;
    logic        memRead;
    logic        memWrite;
    logic        memToReg;
    wordT        aluOut;
    wordT        storeData;
    wordT        pcIn;
    excCodeE     excIn;
    wordT        memRdata;
    logic        memAddrOk;
    logic        memDataOk;
    wordT        writeData;
    laneT        rfByteEn;
    logic        stall;
    logic        memReq;
    logic        memWr;
    logic [31:0] memAddr;
    laneT        memStrb;
    wordT        memWdata;
    int          acceptCnt;
    logic        logWr;
    logic [31:0] logAddr;
    laneT        logStrb;
    wordT        logWdata;

    integer  seed = 32'hc417;
    int      errCount = 0;
    int      checkCount = 0;
    int      cycles = 0;
    int      expAccepts = 0;
    excCodeE prevExcModel = excNone;

    memStage i_memStage (.*);

    sramResponder i_sramResponder (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, an access never completed", cycles);
        $display("%0d errors in %0d checks", errCount, checkCount);
        $display("Test failed");
        $finish;
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("error %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    function automatic memTypeE pickType(input int i);
        case (i)
            0:       return mtByteU;
            1:       return mtHalfU;
            2:       return mtWord;
            3:       return mtLeft;
            4:       return mtByteS;
            5:       return mtHalfS;
            default: return mtRight;
        endcase
    endfunction

    // lanes and shifted data per byte offset
    task automatic modelStore(input memTypeE mt, input wordT sd, input int o,
                              output laneT strb, output wordT data);
        case (mt)
            mtByteU, mtByteS: begin
                strb = 4'b0001 << o;
                data = {24'b0, sd[7:0]} << (8 * o);
            end
            mtHalfU, mtHalfS: begin
                strb = 4'b0011 << o;
                data = {16'b0, sd[15:0]} << (8 * o);
            end
            mtLeft: begin
                strb = 4'b1111 >> (3 - o);
                data = sd >> (8 * (3 - o));
            end
            mtRight: begin
                strb = 4'b1111 << o;
                data = sd << (8 * o);
            end
            default: begin
                strb = 4'b1111;
                data = sd;
            end
        endcase
    endtask

    task automatic modelLoad(input memTypeE mt, input wordT w, input int o,
                             output wordT data, output laneT en);
        logic [7:0]  b;
        logic [15:0] h;
        b  = w[8 * o +: 8];
        h  = w[8 * (o & 2) +: 16];
        en = 4'b1111;
        case (mt)
            mtByteU: data = {24'b0, b};
            mtByteS: data = {{24{b[7]}}, b};
            mtHalfU: data = {16'b0, h};
            mtHalfS: data = {{16{h[15]}}, h};
            mtLeft: begin   // low memory bytes land at the top
                data = w << (8 * (3 - o));
                en   = 4'b1111 << (3 - o);
            end
            mtRight: begin
                data = w >> (8 * o);
                en   = 4'b1111 >> o;
            end
            default: data = w;
        endcase
    endtask

    task automatic runOp();
        int          kind;
        int          excSel;
        int          o;
        memTypeE     mt;
        excCodeE     exc;
        logic        isLoad;
        logic        isStore;
        logic        legal;
        logic        done;
        wordT        a;
        wordT        sd;
        wordT        pc;
        logic [31:0] phys;
        laneT        expStrb;
        wordT        expWdata;
        wordT        expLoad;
        laneT        expEn;
        kind    = {$random(seed)} % 8;
        excSel  = {$random(seed)} % 8;
        mt      = pickType({$random(seed)} % 7);
        isLoad  = kind < 3;
        isStore = kind >= 3 && kind < 6;
        a       = $random(seed);
        sd      = $random(seed);
        pc      = $random(seed);
        if (mt == mtHalfU || mt == mtHalfS) a[0] = 1'b0;
        if (mt == mtWord) a[1:0] = 2'b00;
        pc[1:0] = (excSel == 2) ? 2'(1 + {$random(seed)} % 3) : 2'b00;
        exc     = (excSel == 0) ? excSys : (excSel == 1) ? excEret :
                  (excSel == 3) ? excOv : excNone;
        legal   = (isLoad || isStore) && exc == excNone && pc[1:0] == 2'b00
                  && (prevExcModel == excNone || prevExcModel == excEret);
        prevExcModel = exc;
        o    = a[1:0];
        phys = a & 32'h1FFF_FFFF;
        modelStore(mt, sd, o, expStrb, expWdata);
        modelLoad(mt, (phys >> 2) ^ 32'h5A3C_96E1, o, expLoad, expEn);

        @(posedge clk);
        memType   <= mt;
        memRead   <= isLoad;
        memWrite  <= isStore;
        memToReg  <= isLoad;
        aluOut    <= a;
        storeData <= sd;
        pcIn      <= pc;
        excIn     <= exc;

        @(negedge clk);
        if (legal) begin
            expAccepts++;
            checkValue("memReq", memReq, 1);   // request in the issue cycle
            done = 1'b0;
            while (!done) begin
                if (memDataOk) begin
                    checkValue("stall", stall, 0);
                    if (isLoad) begin
                        checkValue("writeData", writeData, expLoad);
                        checkValue("rfByteEn", rfByteEn, expEn);
                    end
                    done = 1'b1;
                end else begin
                    checkValue("stall", stall, 1);
                    if (memReq) begin   // fields must hold until accepted
                        checkValue("memWr", memWr, isStore);
                        checkValue("memAddr", memAddr, phys);
                        if (isStore) begin
                            checkValue("memStrb", memStrb, expStrb);
                            checkValue("memWdata", memWdata, expWdata);
                        end
                    end
                    @(negedge clk);
                end
            end
            checkValue("logAddr", logAddr, phys);
            checkValue("logWr", logWr, isStore);
            if (isStore) begin
                checkValue("logStrb", logStrb, expStrb);
                checkValue("logWdata", logWdata, expWdata);
            end
        end else begin
            checkValue("stall", stall, 0);
            checkValue("memReq", memReq, 0);
            if (!isLoad) begin
                checkValue("writeData", writeData, a);
                checkValue("rfByteEn", rfByteEn, 4'b1111);
            end
        end
        checkValue("acceptCnt", acceptCnt, expAccepts);
    endtask

    initial begin
        rst       = 1'b1;
        memType   = mtWord;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        aluOut    = '0;
        storeData = '0;
        pcIn      = '0;
        excIn     = excNone;

        repeat (resetCycles) begin
            @(negedge clk);
            checkValue("memReq", memReq, 0);
            checkValue("stall", stall, 0);
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);   // first cycle out of reset
        checkValue("memReq", memReq, 0);
        checkValue("stall", stall, 0);

        for (int n = 0; n < opCount; n++) begin
            runOp();
        end

        $display("%0d errors in %0d checks", errCount, checkCount);
        if (errCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
src/memOpPkg.sv
src/memBusPkg.sv
src/storeLaneIf.sv
src/storeAlign.sv
src/loadAlign.sv
src/memAccessCtrl.sv
src/memStage.sv
testbench/sramResponder.sv
testbench/memStageTb.sv

// File: Bender.yml
package:
  name: memStage

sources:
  - src/memOpPkg.sv
  - src/memBusPkg.sv
  - src/storeLaneIf.sv
  - src/storeAlign.sv
  - src/loadAlign.sv
  - src/memAccessCtrl.sv
  - src/memStage.sv
  - target: test
    files:
      - testbench/sramResponder.sv
      - testbench/memStageTb.sv
